// File: hdl/vmul_pkg.sv
/*
 * vector multiply unit shared types
 * element width, fused operation codes and the multiplier depth
 */

package vmul_pkg;

  // element width of one lane operand
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // fused operation select
  // vs2/vs3 role swaps between the acc and add forms
  typedef enum logic [2:0] {
    // product only
    MUL  = 3'd0,
    // vs3 + vs2 * vs1
    MACC = 3'd1,
    // vs3 - vs2 * vs1
    MSAC = 3'd2,
    // vs2 + vs3 * vs1
    MADD = 3'd3,
    // vs2 - vs3 * vs1
    MSUB = 3'd4
  } mul_op_t;

  // register stages between operand capture and product
  // sideband and valid tracking have to match this depth
  localparam int MUL_STAGES = 3;

endpackage

// File: hdl/operand_prep.sv
/*
 * operand preparation for the lane multiplier
 * extends narrow elements and picks multiplicand, multiplier and addend
 */

`timescale 1ns/1ps

module operand_prep (
  input  vmul_pkg::sew_t    sew,
  input  vmul_pkg::mul_op_t mul_op,
  input  logic [1:0]        is_signed,
  input  logic [31:0]       vs1_data,
  input  logic [31:0]       vs2_data,
  input  logic [31:0]       vs3_data,
  output logic [31:0]       multiplicand,
  output logic [31:0]       multiplier,
  output logic [31:0]       addend,
  output logic              mcand_signed,
  output logic              mplier_signed
);
  import vmul_pkg::*;

  logic [31:0] vs1_ext;
  logic [31:0] vs2_ext;
  logic [31:0] vs3_ext;
  logic        from_vs3;

  // upper register bits above a narrow element are ignored
  // bit 0 of is_signed covers vs1, bit 1 covers vs2
  always_comb begin
    vs1_ext = vs1_data;
    vs2_ext = vs2_data;
    vs3_ext = vs3_data;
    case (sew)
      SEW8: begin
        vs1_ext = {{24{is_signed[0] & vs1_data[7]}}, vs1_data[7:0]};
        vs2_ext = {{24{is_signed[1] & vs2_data[7]}}, vs2_data[7:0]};
        // vs3 is always a signed accumulator source
        vs3_ext = {{24{vs3_data[7]}}, vs3_data[7:0]};
      end
      SEW16: begin
        vs1_ext = {{16{is_signed[0] & vs1_data[15]}}, vs1_data[15:0]};
        vs2_ext = {{16{is_signed[1] & vs2_data[15]}}, vs2_data[15:0]};
        vs3_ext = {{16{vs3_data[15]}}, vs3_data[15:0]};
      end
      default: ;
    endcase
  end

  // add forms multiply vs3 and accumulate onto vs2
  assign from_vs3 = (mul_op == MADD) || (mul_op == MSUB);

  assign multiplicand  = from_vs3 ? vs3_ext : vs2_ext;
  assign addend        = from_vs3 ? vs2_ext : vs3_ext;
  assign multiplier    = vs1_ext;
  assign mcand_signed  = from_vs3 ? 1'b1 : is_signed[1];
  assign mplier_signed = is_signed[0];

endmodule

// File: hdl/pipe_multiplier.sv
/*
 * three stage 33x33 multiplier
 * 16-bit partial products, pairwise add, final sum into a 64-bit product
 * each stage register loads only on its own enable
 */

`timescale 1ns/1ps

module pipe_multiplier (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [2:0]  stage_en,
  input  logic [31:0] multiplicand,
  input  logic [31:0] multiplier,
  input  logic        mcand_signed,
  input  logic        mplier_signed,
  output logic [63:0] product
);

  // 33rd bit of each operand has weight -2^32 when set
  logic        a_top;
  logic        b_top;
  logic [31:0] corr;

  // stage one registers
  logic [31:0] pp_ll, pp_lh, pp_hl, pp_hh;
  logic [31:0] corr_q;
  // stage two registers
  logic [63:0] outer_q;
  logic [32:0] mid_q;

  assign a_top = mcand_signed & multiplicand[31];
  assign b_top = mplier_signed & multiplier[31];

  // only the low 32 bits of the sign correction survive at bit 32 and up
  // a*b = au*bu - a_top*bu<<32 - b_top*au<<32 (mod 2^64)
  assign corr = -((a_top ? multiplier : 32'd0) + (b_top ? multiplicand : 32'd0));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pp_ll   <= '0;
      pp_lh   <= '0;
      pp_hl   <= '0;
      pp_hh   <= '0;
      corr_q  <= '0;
      outer_q <= '0;
      mid_q   <= '0;
      product <= '0;
    end else begin
      // four unsigned 16x16 products
      if (stage_en[0]) begin
        pp_ll  <= multiplicand[15:0] * multiplier[15:0];
        pp_lh  <= multiplicand[15:0] * multiplier[31:16];
        pp_hl  <= multiplicand[31:16] * multiplier[15:0];
        pp_hh  <= multiplicand[31:16] * multiplier[31:16];
        corr_q <= corr;
      end
      // outer pair does not overlap so the correction folds into the top word
      if (stage_en[1]) begin
        outer_q <= {pp_hh + corr_q, pp_ll};
        mid_q   <= {1'b0, pp_lh} + {1'b0, pp_hl};
      end
      // cross terms sit at bit 16
      if (stage_en[2]) begin
        product <= outer_q + {15'd0, mid_q, 16'd0};
      end
    end
  end

endmodule

// File: hdl/mul_control.sv
/*
 * multiply pipeline control
 * valid bit per stage, stage enables, sideband delay and done
 */

`timescale 1ns/1ps

module mul_control (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            start,
  input  vmul_pkg::mul_op_t               mul_op,
  input  vmul_pkg::sew_t                  sew,
  input  logic                            high_low,
  input  logic                            widen,
  input  logic                            negate,
  input  logic [31:0]                     addend,
  output logic [vmul_pkg::MUL_STAGES-1:0] stage_en,
  output vmul_pkg::mul_op_t               op_q,
  output vmul_pkg::sew_t                  sew_q,
  output logic                            high_low_q,
  output logic                            widen_q,
  output logic                            negate_q,
  output logic [31:0]                     addend_q,
  output logic                            done
);
  import vmul_pkg::*;

  logic [MUL_STAGES-1:0] valid;
  mul_op_t               op_sr  [MUL_STAGES];
  sew_t                  sew_sr [MUL_STAGES];
  logic [MUL_STAGES-1:0] hl_sr;
  logic [MUL_STAGES-1:0] widen_sr;
  logic [MUL_STAGES-1:0] neg_sr;
  logic [31:0]           addend_sr [MUL_STAGES];

  // stage k loads while its input holds a live element
  assign stage_en = {valid[MUL_STAGES-2:0], start};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid    <= '0;
      hl_sr    <= '0;
      widen_sr <= '0;
      neg_sr   <= '0;
      for (int i = 0; i < MUL_STAGES; i++) begin
        op_sr[i]  <= MUL;
        sew_sr[i] <= SEW32;
      end
    end else begin
      valid <= stage_en;
      for (int i = 0; i < MUL_STAGES; i++) begin
        if (stage_en[i]) begin
          // same enables as the product stages, so controls stay aligned
          op_sr[i]    <= (i == 0) ? mul_op : op_sr[i-1];
          sew_sr[i]   <= (i == 0) ? sew : sew_sr[i-1];
          hl_sr[i]    <= (i == 0) ? high_low : hl_sr[i-1];
          widen_sr[i] <= (i == 0) ? widen : widen_sr[i-1];
          neg_sr[i]   <= (i == 0) ? negate : neg_sr[i-1];
        end
      end
    end
  end

  // addend rides along with no reset
  always_ff @(posedge CLK) begin
    for (int i = 0; i < MUL_STAGES; i++) begin
      if (stage_en[i]) begin
        addend_sr[i] <= (i == 0) ? addend : addend_sr[i-1];
      end
    end
  end

  // last stage feeds the fuse logic
  assign op_q       = op_sr[MUL_STAGES-1];
  assign sew_q      = sew_sr[MUL_STAGES-1];
  assign high_low_q = hl_sr[MUL_STAGES-1];
  assign widen_q    = widen_sr[MUL_STAGES-1];
  assign negate_q   = neg_sr[MUL_STAGES-1];
  assign addend_q   = addend_sr[MUL_STAGES-1];
  assign done       = valid[MUL_STAGES-1];

endmodule

// File: hdl/result_fuse.sv
/*
 * result selection and fused accumulate
 * slices the product by width, then optional negate and add or subtract
 */

`timescale 1ns/1ps

module result_fuse (
  input  logic [63:0]       product,
  input  vmul_pkg::mul_op_t op_q,
  input  vmul_pkg::sew_t    sew_q,
  input  logic              high_low_q,
  input  logic              widen_q,
  input  logic              negate_q,
  input  logic [31:0]       addend_q,
  output logic [31:0]       wdata
);
  import vmul_pkg::*;

  logic [31:0] slice;
  logic [31:0] term;

  // high half beats widen on the narrow widths
  always_comb begin
    case (sew_q)
      SEW32: begin
        // widen has no meaning at full width
        slice = high_low_q ? product[63:32] : product[31:0];
      end
      SEW16: begin
        if (high_low_q)   slice = {16'd0, product[31:16]};
        else if (widen_q) slice = product[31:0];
        else              slice = {16'd0, product[15:0]};
      end
      SEW8: begin
        if (high_low_q)   slice = {24'd0, product[15:8]};
        else if (widen_q) slice = {16'd0, product[15:0]};
        else              slice = {24'd0, product[7:0]};
      end
      default: slice = '0;
    endcase
  end

  // negate only matters for the fused forms
  assign term = negate_q ? (32'd0 - slice) : slice;

  // everything wraps modulo 2^32
  always_comb begin
    case (op_q)
      MACC, MADD: wdata = addend_q + term;
      MSAC, MSUB: wdata = addend_q - term;
      default:    wdata = slice;
    endcase
  end

endmodule

// File: hdl/vmul_unit.sv
/*
 * vector lane multiply unit
 * start/done handshake, three cycles from start to write-back data
 */

`timescale 1ns/1ps

module vmul_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              start,
  input  vmul_pkg::sew_t    sew,
  input  vmul_pkg::mul_op_t mul_op,
  input  logic [1:0]        is_signed,
  input  logic              high_low,
  input  logic              widen,
  input  logic              negate,
  input  logic [31:0]       vs1_data,
  input  logic [31:0]       vs2_data,
  input  logic [31:0]       vs3_data,
  output logic              done,
  output logic [31:0]       wdata
);
  import vmul_pkg::*;

  // prepared operands
  logic [31:0] multiplicand;
  logic [31:0] multiplier;
  logic [31:0] addend;
  logic        mcand_signed;
  logic        mplier_signed;

  // pipeline enables and product
  logic [2:0]  stage_en;
  logic [63:0] product;

  // last stage sideband
  mul_op_t     op_q;
  sew_t        sew_q;
  logic        high_low_q;
  logic        widen_q;
  logic        negate_q;
  logic [31:0] addend_q;

  operand_prep operand_prep_i (
    .sew(sew), .mul_op(mul_op), .is_signed(is_signed),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data),
    .multiplicand(multiplicand), .multiplier(multiplier), .addend(addend),
    .mcand_signed(mcand_signed), .mplier_signed(mplier_signed)
  );

  mul_control mul_control_i (
    .CLK(CLK), .nRST(nRST), .start(start), .mul_op(mul_op), .sew(sew),
    .high_low(high_low), .widen(widen), .negate(negate), .addend(addend),
    .stage_en(stage_en), .op_q(op_q), .sew_q(sew_q), .high_low_q(high_low_q),
    .widen_q(widen_q), .negate_q(negate_q), .addend_q(addend_q), .done(done)
  );

  pipe_multiplier pipe_multiplier_i (
    .CLK(CLK), .nRST(nRST), .stage_en(stage_en),
    .multiplicand(multiplicand), .multiplier(multiplier),
    .mcand_signed(mcand_signed), .mplier_signed(mplier_signed), .product(product)
  );

  result_fuse result_fuse_i (
    .product(product), .op_q(op_q), .sew_q(sew_q), .high_low_q(high_low_q),
    .widen_q(widen_q), .negate_q(negate_q), .addend_q(addend_q), .wdata(wdata)
  );

endmodule

// File: sim/vmul_unit_checker.sv
/*
 * handshake checker for the vector lane multiply unit
 * done timing against start, clean wdata on done, quiet reset
 */

`timescale 1ns/1ps

module vmul_unit_checker (
  input logic        CLK,
  input logic        nRST,
  input logic        start,
  input logic        done,
  input logic [31:0] wdata
);
  import vmul_pkg::*;

  // one done per start, exactly the pipe depth later
  done_after_start: assert property (@(posedge CLK) disable iff (!nRST)
      done == $past(start, MUL_STAGES))
    else $error("done does not match start from %0d cycles earlier", MUL_STAGES);

  // write-back data fully known while done is high
  wdata_known: assert property (@(posedge CLK) disable iff (!nRST)
      done |-> !$isunknown(wdata))
    else $error("wdata has unknown bits while done is high");

  // nothing leaves the unit while reset is held
  quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !done)
    else $error("done is high during reset");

endmodule

bind vmul_unit vmul_unit_checker vmul_unit_checker_i (
  .CLK(CLK), .nRST(nRST), .start(start), .done(done), .wdata(wdata)
);

// File: sim/vmul_unit_tb.sv
/*
 * testbench for the vector lane multiply unit
 * directed tests against a reference model of the lane rules
 * every done is checked against its element's value and arrival cycle
 */

`timescale 1ns/1ps

module vmul_unit_tb;
  import vmul_pkg::*;

  logic              CLK = 1'b0;
  logic              nRST;
  logic              start;
  sew_t              sew;
  mul_op_t           mul_op;
  logic [1:0]        is_signed;
  logic              high_low;
  logic              widen;
  logic              negate;
  logic [31:0]       vs1_data;
  logic [31:0]       vs2_data;
  logic [31:0]       vs3_data;
  logic              done;
  logic [31:0]       wdata;

  integer            seed = 41895;
  int                cyc = 0;
  // expected results and the cycle each one is due with the oldest first
  logic [31:0]       exp_val [$];
  int                exp_due [$];
  logic [31:0]       edge_vals [5] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                                       32'h0000_0001, 32'h0000_0000};
  // low halves with the element sign bits in both byte and halfword
  logic [15:0]       lows [4] = '{16'h8080, 16'hFFFF, 16'h7F01, 16'h00FE};

  vmul_unit vmul_unit_i (
    .CLK(CLK), .nRST(nRST), .start(start), .sew(sew), .mul_op(mul_op),
    .is_signed(is_signed), .high_low(high_low), .widen(widen), .negate(negate),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data),
    .done(done), .wdata(wdata)
  );

  // 4 ns clock
  always #2 CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // element of width w as a signed or unsigned 64-bit value
  function automatic logic [63:0] ext_elem(input logic [31:0] v, input int w,
                                           input logic sg);
    logic [63:0] m;
    logic [63:0] r;
    m = (64'd1 << w) - 64'd1;
    r = {32'd0, v} & m;
    if (sg && r[w-1]) r = r | ~m;
    return r;
  endfunction

  function automatic logic [31:0] ref_result(input sew_t s, input mul_op_t op,
      input logic [1:0] sg, input logic hl, input logic wd, input logic ng,
      input logic [31:0] v1, input logic [31:0] v2, input logic [31:0] v3);
    int          w;
    logic        swap;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] p;
    logic [31:0] sl;
    logic [31:0] term;
    w = (s == SEW8) ? 8 : (s == SEW16) ? 16 : 32;
    swap = (op == MADD) || (op == MSUB);
    // vs3 always enters as signed
    a = swap ? ext_elem(v3, w, 1'b1) : ext_elem(v2, w, sg[1]);
    c = swap ? ext_elem(v2, w, sg[1]) : ext_elem(v3, w, 1'b1);
    b = ext_elem(v1, w, sg[0]);
    p = a * b;
    // high half of the 2w product or 2w bits for widen or else w bits
    if (hl) sl = 32'((p >> w) & ((64'd1 << w) - 64'd1));
    else if (wd && w < 32) sl = 32'(p & ((64'd1 << (2 * w)) - 64'd1));
    else sl = 32'(p & ((64'd1 << w) - 64'd1));
    term = ng ? (32'd0 - sl) : sl;
    case (op)
      MACC, MADD: return c[31:0] + term;
      MSAC, MSUB: return c[31:0] - term;
      default:    return sl;
    endcase
  endfunction

  // drives one element at a falling edge and leaves start high
  task automatic send(input sew_t s, input mul_op_t op, input logic [1:0] sg,
      input logic hl, input logic wd, input logic ng,
      input logic [31:0] v1, input logic [31:0] v2, input logic [31:0] v3);
    start     = 1'b1;
    sew       = s;
    mul_op    = op;
    is_signed = sg;
    high_low  = hl;
    widen     = wd;
    negate    = ng;
    vs1_data  = v1;
    vs2_data  = v2;
    vs3_data  = v3;
    exp_val.push_back(ref_result(s, op, sg, hl, wd, ng, v1, v2, v3));
    exp_due.push_back(cyc + 3);
    @(negedge CLK);
  endtask

  task automatic wait_drain();
    int n;
    start = 1'b0;
    n = 0;
    while (exp_val.size() != 0 && n < 20) begin
      @(posedge CLK);
      n++;
    end
    if (exp_val.size() != 0) begin
      $display("timeout: done never arrived for %0d elements", exp_val.size());
      stop_run();
    end
    @(negedge CLK);
  endtask

  // result checker on every falling edge
  always @(negedge CLK) begin
    if (nRST && done) begin
      assert (exp_val.size() != 0) else begin
        $display("done was raised with no element in flight");
        stop_run();
      end
      assert (cyc == exp_due[0]) else begin
        $display("ERROR %0t: done cycle got %0d expected %0d", $time, cyc, exp_due[0]);
        stop_run();
      end
      assert (wdata === exp_val[0]) else begin
        $display("ERROR %0t: wdata got %h expected %h", $time, wdata, exp_val[0]);
        stop_run();
      end
      void'(exp_val.pop_front());
      void'(exp_due.pop_front());
    end else if (nRST && exp_due.size() != 0) begin
      assert (exp_due[0] > cyc) else begin
        $display("done did not arrive in the cycle its element was due");
        stop_run();
      end
    end
  end

  task automatic idle_after_reset();
    repeat (6) begin
      @(negedge CLK);
      assert (done === 1'b0) else begin
        $display("ERROR %0t: done got %b expected 0", $time, done);
        stop_run();
      end
      assert (wdata === 32'd0) else begin
        $display("ERROR %0t: wdata got %h expected 00000000", $time, wdata);
        stop_run();
      end
    end
  endtask

  task automatic mul32_edges();
    for (int sg = 0; sg < 4; sg++)
      for (int hl = 0; hl < 2; hl++)
        for (int i = 0; i < 5; i++)
          for (int j = 0; j < 5; j++)
            send(SEW32, MUL, 2'(sg), 1'(hl), 1'b0, 1'b0, edge_vals[i], edge_vals[j],
                 32'hDEAD_BEEF);
    wait_drain();
  endtask

  // mode bit 1 is high_low and bit 0 is widen
  task automatic narrow_mul();
    logic [31:0] a;
    logic [31:0] b;
    for (int s = 0; s < 2; s++)
      for (int mode = 0; mode < 4; mode++)
        for (int sg = 0; sg < 4; sg++)
          for (int k = 0; k < 4; k++) begin
            // garbage above the element
            a = {16'($random(seed)), lows[k]};
            b = {16'($random(seed)), lows[3-k]};
            send(sew_t'(2'(s)), MUL, 2'(sg), mode[1], mode[0], 1'b0, a, b, $random(seed));
          end
    wait_drain();
  endtask

  task automatic fused_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    for (int s = 0; s < 3; s++)
      for (int op = 1; op < 5; op++)
        for (int ng = 0; ng < 2; ng++)
          for (int k = 0; k < 6; k++) begin
            a = $random(seed);
            b = $random(seed);
            c = $random(seed);
            // narrow sign bits of vs3 set on odd k
            if (k % 2 == 1) c = c | 32'h8000_8080;
            send(sew_t'(2'(s)), mul_op_t'(3'(op)), 2'($random(seed)), k == 4, k == 5,
                 1'(ng), a, b, c);
          end
    wait_drain();
  endtask

  // start held high for the whole burst
  task automatic random_burst();
    logic [31:0] r;
    for (int n = 0; n < 40; n++) begin
      r = $random(seed);
      send(sew_t'(2'(r[7:0] % 3)), mul_op_t'(3'(r[15:8] % 5)), r[17:16], r[18], r[19],
           r[20], $random(seed), $random(seed), $random(seed));
    end
    wait_drain();
  endtask

  initial begin
    nRST      = 1'b0;
    start     = 1'b0;
    sew       = SEW32;
    mul_op    = MUL;
    is_signed = 2'b00;
    high_low  = 1'b0;
    widen     = 1'b0;
    negate    = 1'b0;
    vs1_data  = 32'd0;
    vs2_data  = 32'd0;
    vs3_data  = 32'd0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    idle_after_reset();
    mul32_edges();
    narrow_mul();
    fused_ops();
    random_burst();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: vlog.f
hdl/vmul_pkg.sv
hdl/operand_prep.sv
hdl/pipe_multiplier.sv
hdl/mul_control.sv
hdl/result_fuse.sv
hdl/vmul_unit.sv
sim/vmul_unit_checker.sv
sim/vmul_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the vmul_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module vmul_unit_tb -f vlog.f -o vmul_sim

out=$(./obj_dir/vmul_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
else
  exit 1
fi
